//--- design/data_bus.sv
`timescale 1ns/1ps
`default_nettype none

`include "periph_config.svh"

module data_bus (
    input  logic                clk,
    input  logic                rst_n,
    input  periph_pkg::bus_req_t cpu_req,
    output periph_pkg::bus_rsp_t cpu_rsp,
    output periph_pkg::bus_req_t ram_req,
    output periph_pkg::bus_req_t timer_req,
    output periph_pkg::bus_req_t gpio_req,
    input  periph_pkg::bus_rsp_t ram_rsp,
    input  periph_pkg::bus_rsp_t timer_rsp,
    input  periph_pkg::bus_rsp_t gpio_rsp
);

    periph_pkg::addr_t      window;
    periph_pkg::slave_sel_t hit;
    logic                   miss;

    periph_pkg::bus_req_t   req_q;   // shared payload towards the slaves
    periph_pkg::slave_sel_t sel_q;   // slave valid bits, cycle N+1
    periph_pkg::slave_sel_t sel_d2;  // response steering, cycle N+2
    logic                   err_d1;
    logic                   err_d2;

    assign window = cpu_req.addr & `WINDOW_MASK;

    always_comb begin
        hit = '0;
        if (cpu_req.valid) begin
            hit[periph_pkg::sel_ram]   = (window == `RAM_BASE);
            hit[periph_pkg::sel_timer] = (window == `TIMER_BASE);
            // gpio window falls through to err when the block is left out
            hit[periph_pkg::sel_gpio]  = (window == `GPIO_BASE) &&
                                         (`ENABLE_PERIPHERAL_GPIO != 0);
        end
    end

    assign miss = cpu_req.valid && (hit == '0);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sel_q  <= '0;
            sel_d2 <= '0;
            err_d1 <= 1'b0;
            err_d2 <= 1'b0;
        end else begin
            sel_q  <= hit;
            sel_d2 <= sel_q;
            err_d1 <= miss;
            err_d2 <= err_d1;
        end
    end

    always_ff @(posedge clk) begin
        if (cpu_req.valid) begin
            req_q <= cpu_req;
        end
    end

    always_comb begin
        ram_req         = req_q;
        ram_req.valid   = sel_q[periph_pkg::sel_ram];
        timer_req       = req_q;
        timer_req.valid = sel_q[periph_pkg::sel_timer];
        gpio_req        = req_q;
        gpio_req.valid  = sel_q[periph_pkg::sel_gpio];
    end

    // slave responses are already registered, steer them straight through
    always_comb begin
        cpu_rsp = periph_pkg::rsp_idle;
        if (err_d2) begin
            cpu_rsp.ack = 1'b1;
            cpu_rsp.err = 1'b1;
        end else if (sel_d2[periph_pkg::sel_ram]) begin
            cpu_rsp = ram_rsp;
        end else if (sel_d2[periph_pkg::sel_timer]) begin
            cpu_rsp = timer_rsp;
        end else if (sel_d2[periph_pkg::sel_gpio]) begin
            cpu_rsp = gpio_rsp;
        end
    end

endmodule

`default_nettype wire

//--- design/gpio_controller.sv
`timescale 1ns/1ps
`default_nettype none

`include "periph_config.svh"

module gpio_controller (
    input  logic                clk,
    input  logic                rst_n,
    input  periph_pkg::bus_req_t bus_req,
    output periph_pkg::bus_rsp_t bus_rsp,
    input  periph_pkg::word_t   gpio_in,
    output periph_pkg::word_t   gpio_out
);

    periph_pkg::word_t out_q;
    periph_pkg::word_t sync1_q;  // two-flop synchroniser
    periph_pkg::word_t sync2_q;
    periph_pkg::word_t in_q;     // IN register
    periph_pkg::word_t rdata_q;
    logic              ack_q;

    logic [3:0] offset;

    assign offset = bus_req.addr[3:0];

    always_ff @(posedge clk) begin
        sync1_q <= gpio_in;
        sync2_q <= sync1_q;
        in_q    <= sync2_q;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_q <= '0;
            ack_q <= 1'b0;
        end else begin
            ack_q <= bus_req.valid;
            // IN is read-only, writes there just get acked
            if (bus_req.valid && bus_req.we && (offset == `GPIO_OUT_OFS)) begin
                out_q <= bus_req.wdata;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (bus_req.valid) begin
            if (bus_req.we) begin
                rdata_q <= '0;
            end else if (offset == `GPIO_OUT_OFS) begin
                rdata_q <= out_q;
            end else if (offset == `GPIO_IN_OFS) begin
                rdata_q <= in_q;
            end else begin
                rdata_q <= '0;
            end
        end
    end

    assign gpio_out = out_q;

    always_comb begin
        bus_rsp.ack   = ack_q;
        bus_rsp.err   = 1'b0;
        bus_rsp.rdata = rdata_q;
    end

endmodule

`default_nettype wire

//--- design/periph_config.svh
`ifndef PERIPH_CONFIG_SVH
`define PERIPH_CONFIG_SVH

// upper nibble picks the slave
`define WINDOW_MASK 32'hF000_0000

// on-chip ram, 4 KiB window
`define RAM_BASE 32'h0000_0000
`define RAM_WORDS 1024
`define RAM_INDEX_BITS 10

// timer registers
`define TIMER_BASE 32'h1000_0000
`define TIMER_COUNT_OFS 4'h0
`define TIMER_COMPARE_OFS 4'h4
`define TIMER_STATUS_OFS 4'h8

// gpio registers
`define GPIO_BASE 32'h2000_0000
`define GPIO_OUT_OFS 4'h0
`define GPIO_IN_OFS 4'h4

`define ENABLE_PERIPHERAL_GPIO 1

`endif

//--- design/periph_pkg.sv
`default_nettype none

package periph_pkg;

    typedef logic [31:0] word_t;  // data word
    typedef logic [31:0] addr_t;  // byte address

    // one-hot slave select, bit positions below
    typedef logic [2:0] slave_sel_t;

    localparam int sel_ram   = 0;
    localparam int sel_timer = 1;
    localparam int sel_gpio  = 2;

    // 66 bits
    typedef struct packed {
        logic  valid;  // one-cycle strobe
        logic  we;
        addr_t addr;
        word_t wdata;
    } bus_req_t;

    // 34 bits
    typedef struct packed {
        logic  ack;    // one-cycle pulse
        logic  err;    // unmapped address
        word_t rdata;
    } bus_rsp_t;

    localparam bus_rsp_t rsp_idle = '{
        ack:   1'b0,
        err:   1'b0,
        rdata: '0
    };

endpackage

`default_nettype wire

//--- design/periph_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "periph_config.svh"

module periph_top (
    input  logic                clk,
    input  logic                rst_n,
    input  periph_pkg::bus_req_t cpu_req,
    output periph_pkg::bus_rsp_t cpu_rsp,
    input  periph_pkg::word_t   gpio_in,
    output periph_pkg::word_t   gpio_out,
    output logic                timer_irq
);

    periph_pkg::bus_req_t ram_req;
    periph_pkg::bus_req_t timer_req;
    periph_pkg::bus_req_t gpio_req;
    periph_pkg::bus_rsp_t ram_rsp;
    periph_pkg::bus_rsp_t timer_rsp;
    periph_pkg::bus_rsp_t gpio_rsp;

    data_bus data_bus_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .cpu_req   (cpu_req),
        .cpu_rsp   (cpu_rsp),
        .ram_req   (ram_req),
        .timer_req (timer_req),
        .gpio_req  (gpio_req),
        .ram_rsp   (ram_rsp),
        .timer_rsp (timer_rsp),
        .gpio_rsp  (gpio_rsp)
    );

    ram_controller ram_controller_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .bus_req (ram_req),
        .bus_rsp (ram_rsp)
    );

    timer_controller timer_controller_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .bus_req (timer_req),
        .bus_rsp (timer_rsp),
        .irq     (timer_irq)
    );

    // optional gpio, decoder maps its window to err when absent
    generate
        if (`ENABLE_PERIPHERAL_GPIO) begin : g_gpio
            gpio_controller gpio_controller_inst (
                .clk      (clk),
                .rst_n    (rst_n),
                .bus_req  (gpio_req),
                .bus_rsp  (gpio_rsp),
                .gpio_in  (gpio_in),
                .gpio_out (gpio_out)
            );
        end else begin : g_no_gpio
            assign gpio_rsp = periph_pkg::rsp_idle;
            assign gpio_out = '0;
        end
    endgenerate

endmodule

`default_nettype wire

//--- design/ram_controller.sv
`timescale 1ns/1ps
`default_nettype none

`include "periph_config.svh"

module ram_controller (
    input  logic                clk,
    input  logic                rst_n,
    input  periph_pkg::bus_req_t bus_req,
    output periph_pkg::bus_rsp_t bus_rsp
);

    periph_pkg::word_t mem [`RAM_WORDS];

    logic [`RAM_INDEX_BITS-1:0] index;
    logic                       ack_q;
    periph_pkg::word_t          rdata_q;

    // upper address bits ignored, accesses wrap over the depth
    assign index = bus_req.addr[`RAM_INDEX_BITS+1:2];

    always_ff @(posedge clk) begin
        if (bus_req.valid && bus_req.we) begin
            mem[index] <= bus_req.wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (bus_req.valid) begin
            rdata_q <= bus_req.we ? '0 : mem[index];  // old word on read
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= bus_req.valid;
        end
    end

    always_comb begin
        bus_rsp.ack   = ack_q;
        bus_rsp.err   = 1'b0;
        bus_rsp.rdata = rdata_q;
    end

endmodule

`default_nettype wire

//--- design/timer_controller.sv
`timescale 1ns/1ps
`default_nettype none

`include "periph_config.svh"

module timer_controller (
    input  logic                clk,
    input  logic                rst_n,
    input  periph_pkg::bus_req_t bus_req,
    output periph_pkg::bus_rsp_t bus_rsp,
    output logic                irq
);

    periph_pkg::word_t count_q;
    periph_pkg::word_t compare_q;
    logic              status_q;  // sticky compare hit
    logic              ack_q;
    periph_pkg::word_t rdata_q;

    logic [3:0] offset;
    logic       wr_count;
    logic       wr_compare;
    logic       clr_status;

    assign offset     = bus_req.addr[3:0];
    assign wr_count   = bus_req.valid && bus_req.we && (offset == `TIMER_COUNT_OFS);
    assign wr_compare = bus_req.valid && bus_req.we && (offset == `TIMER_COMPARE_OFS);
    assign clr_status = bus_req.valid && bus_req.we && (offset == `TIMER_STATUS_OFS) &&
                        bus_req.wdata[0];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count_q   <= '0;
            compare_q <= '1;
            status_q  <= 1'b0;
        end else begin
            count_q <= wr_count ? bus_req.wdata : count_q + 1'b1;
            if (wr_compare) begin
                compare_q <= bus_req.wdata;
            end
            // a hit in the same cycle as the clear wins
            if (count_q == compare_q) begin
                status_q <= 1'b1;
            end else if (clr_status) begin
                status_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (bus_req.valid) begin
            rdata_q <= '0;
            if (!bus_req.we) begin
                case (offset)
                    `TIMER_COUNT_OFS:   rdata_q <= count_q;  // value in N+1
                    `TIMER_COMPARE_OFS: rdata_q <= compare_q;
                    `TIMER_STATUS_OFS:  rdata_q <= {31'b0, status_q};
                    default:            rdata_q <= '0;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= bus_req.valid;
        end
    end

    assign irq = status_q;

    always_comb begin
        bus_rsp.ack   = ack_q;
        bus_rsp.err   = 1'b0;
        bus_rsp.rdata = rdata_q;
    end

endmodule

`default_nettype wire

//--- dv/periph_checker.sv
`timescale 1ns/1ps
`default_nettype none

module periph_checker (
    input logic                 clk,
    input logic                 rst_n,
    input periph_pkg::bus_req_t cpu_req,
    input periph_pkg::bus_rsp_t cpu_rsp,
    input periph_pkg::word_t    gpio_out,
    input logic                 timer_irq
);

    logic [32:0] exp_q [$];  // {err, rdata}
    int          due_q [$];  // negedge index of the expected ack
    int          cyc = 0;
    int          mismatches = 0;
    int          missing = 0;
    int          others = 0;

    task automatic push_expect(input logic err, input periph_pkg::word_t rdata);
        exp_q.push_back({err, rdata});
    endtask

    function automatic int outstanding();
        return exp_q.size();
    endfunction

    function automatic int error_total();
        return mismatches + missing + others;
    endfunction

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            mismatches++;
            $display("Mismatch %s: got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic report_failure(input string msg);
        others++;
        $display("%s", msg);
    endtask

    task automatic check_idle();
        compare("cpu_rsp.ack", {31'b0, cpu_rsp.ack}, 32'h0);
        compare("timer_irq", {31'b0, timer_irq}, 32'h0);
        compare("gpio_out", gpio_out, 32'h0);
    endtask

    task automatic check_irq(input logic exp);
        compare("timer_irq", {31'b0, timer_irq}, {31'b0, exp});
    endtask

    task automatic check_gpio_out(input periph_pkg::word_t exp);
        compare("gpio_out", gpio_out, exp);
    endtask

    task automatic print_summary();
        $display("checker: %0d mismatches, %0d missing responses, %0d other errors",
                 mismatches, missing, others);
    endtask

    // outputs are settled at the falling edge
    always @(negedge clk) begin
        logic [32:0] e;
        cyc++;
        if (rst_n) begin
            if (cpu_req.valid) due_q.push_back(cyc + 2);
            if (cpu_rsp.ack) begin
                if (exp_q.size() == 0 || due_q.size() == 0) begin
                    report_failure("ack arrived with no request outstanding");
                end else begin
                    e = exp_q.pop_front();
                    if (due_q.pop_front() != cyc) begin
                        report_failure("ack arrived in the wrong cycle");
                    end
                    compare("cpu_rsp.err", {31'b0, cpu_rsp.err}, {31'b0, e[32]});
                    compare("cpu_rsp.rdata", cpu_rsp.rdata, e[31:0]);
                end
            end else if (due_q.size() > 0 && due_q[0] <= cyc) begin
                missing++;
                $display("no response arrived for the request due in cycle %0d", due_q[0]);
                void'(due_q.pop_front());
                if (exp_q.size() > 0) void'(exp_q.pop_front());
            end
        end
    end

endmodule

`default_nettype wire

//--- dv/periph_properties.sv
`timescale 1ns/1ps
`default_nettype none

module periph_properties (
    input logic                 clk,
    input logic                 rst_n,
    input periph_pkg::bus_req_t cpu_req,
    input periph_pkg::bus_rsp_t cpu_rsp,
    input periph_pkg::bus_req_t ram_req,
    input periph_pkg::bus_req_t timer_req,
    input periph_pkg::bus_req_t gpio_req
);

    req_gets_ack: assert property (@(posedge clk) disable iff (!rst_n)
        cpu_req.valid |-> ##2 cpu_rsp.ack)
        else $error("request without ack two cycles later");

    ack_has_req: assert property (@(posedge clk) disable iff (!rst_n)
        cpu_rsp.ack |-> $past(cpu_req.valid, 2))
        else $error("ack without request two cycles earlier");

    one_slave: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0({ram_req.valid, timer_req.valid, gpio_req.valid}))
        else $error("more than one slave selected");

    err_zero_data: assert property (@(posedge clk) disable iff (!rst_n)
        cpu_rsp.err |-> (cpu_rsp.rdata == '0))
        else $error("err response carries data");

endmodule

bind periph_top periph_properties props_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .cpu_req   (cpu_req),
    .cpu_rsp   (cpu_rsp),
    .ram_req   (ram_req),
    .timer_req (timer_req),
    .gpio_req  (gpio_req)
);

`default_nettype wire

//--- dv/periph_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "periph_config.svh"

module periph_tb;

    typedef struct packed {
        logic              we;
        periph_pkg::addr_t addr;
        periph_pkg::word_t wdata;
        logic [7:0]        gap;          // idle cycles before the request
        logic              exp_err;
        periph_pkg::word_t exp_rdata;
        logic              count_delta;  // expected value from the timer model
    } entry_t;

    logic                 clk;
    logic                 rst_n;
    periph_pkg::bus_req_t cpu_req;
    periph_pkg::bus_rsp_t cpu_rsp;
    periph_pkg::word_t    gpio_in;
    periph_pkg::word_t    gpio_out;
    logic                 timer_irq;

    entry_t            table_q [$];
    periph_pkg::word_t ref_mem [int];
    int                cyc;
    int                base_cycle;  // COUNT equals base_val after this edge
    periph_pkg::word_t base_val;

    localparam periph_pkg::addr_t count_addr = `TIMER_BASE + 32'(`TIMER_COUNT_OFS);
    localparam periph_pkg::addr_t cmp_addr   = `TIMER_BASE + 32'(`TIMER_COMPARE_OFS);
    localparam periph_pkg::addr_t stat_addr  = `TIMER_BASE + 32'(`TIMER_STATUS_OFS);
    localparam periph_pkg::addr_t out_addr   = `GPIO_BASE + 32'(`GPIO_OUT_OFS);
    localparam periph_pkg::addr_t in_addr    = `GPIO_BASE + 32'(`GPIO_IN_OFS);

    periph_top DUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .cpu_req   (cpu_req),
        .cpu_rsp   (cpu_rsp),
        .gpio_in   (gpio_in),
        .gpio_out  (gpio_out),
        .timer_irq (timer_irq)
    );

    periph_checker rsp_check (
        .clk       (clk),
        .rst_n     (rst_n),
        .cpu_req   (cpu_req),
        .cpu_rsp   (cpu_rsp),
        .gpio_out  (gpio_out),
        .timer_irq (timer_irq)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // count seen by a read driven at cycle d
    function automatic periph_pkg::word_t count_at(input int d);
        return base_val + periph_pkg::word_t'(d + 1 - base_cycle);
    endfunction

    function automatic int ram_index(input periph_pkg::addr_t a);
        return int'(a[11:2]);
    endfunction

    task automatic add(input logic we, input periph_pkg::addr_t addr,
                       input periph_pkg::word_t wdata, input int gap,
                       input logic err, input periph_pkg::word_t rdata, input logic delta);
        entry_t e;
        e = '{we, addr, wdata, 8'(gap), err, rdata, delta};
        table_q.push_back(e);
    endtask

    task automatic build_table();
        periph_pkg::addr_t addrs [10];
        periph_pkg::word_t d;
        addrs = '{32'h000, 32'h004, 32'h010, 32'h3FC, 32'h800,
                  32'h124, 32'h200, 32'h040, 32'hFF8, 32'h1004};  // last wraps onto 0x004
        add(1'b0, count_addr, '0, 0, 1'b0, '0, 1'b1);  // first count after reset
        for (int i = 0; i < 10; i++) begin
            d = $urandom;
            ref_mem[ram_index(addrs[i])] = d;
            add(1'b1, addrs[i], d, (i < 5) ? 0 : 1, 1'b0, '0, 1'b0);
        end
        for (int i = 0; i < 10; i++) begin
            add(1'b0, addrs[i], '0, (i % 2) * 2, 1'b0, ref_mem[ram_index(addrs[i])], 1'b0);
        end
        add(1'b0, 32'h3000_0000, '0, 2, 1'b1, '0, 1'b0);
        add(1'b0, addrs[3], '0, 0, 1'b0, ref_mem[ram_index(addrs[3])], 1'b0);
        add(1'b1, 32'hF000_0000, 32'h1234_5678, 1, 1'b1, '0, 1'b0);
        add(1'b0, addrs[9], '0, 0, 1'b0, ref_mem[ram_index(addrs[9])], 1'b0);
        add(1'b1, count_addr, 32'h0000_0100, 2, 1'b0, '0, 1'b0);
        add(1'b0, count_addr, '0, 5, 1'b0, '0, 1'b1);
        add(1'b0, count_addr, '0, 0, 1'b0, '0, 1'b1);
    endtask

    task automatic idle_cycle();
        @(posedge clk);
        cyc++;
        cpu_req <= '0;
    endtask

    task automatic issue(input logic we, input periph_pkg::addr_t addr,
                         input periph_pkg::word_t wdata, input int gap,
                         input logic err, input periph_pkg::word_t rdata);
        repeat (gap) idle_cycle();
        @(posedge clk);
        cyc++;
        cpu_req <= '{1'b1, we, addr, wdata};
        rsp_check.push_expect(err, rdata);
    endtask

    task automatic drain();
        int i;
        for (i = 0; i < 20; i++) begin
            idle_cycle();
            if (rsp_check.outstanding() == 0) break;
        end
        if (i == 20) rsp_check.report_failure("timeout waiting for outstanding responses");
    endtask

    task automatic run_table();
        periph_pkg::word_t exp;
        foreach (table_q[i]) begin
            exp = table_q[i].exp_rdata;
            if (table_q[i].count_delta) exp = count_at(cyc + int'(table_q[i].gap) + 1);
            issue(table_q[i].we, table_q[i].addr, table_q[i].wdata, int'(table_q[i].gap),
                  table_q[i].exp_err, exp);
            if (table_q[i].we && table_q[i].addr == count_addr) begin
                base_cycle = cyc + 2;
                base_val   = table_q[i].wdata;
            end
        end
        drain();
    endtask

    task automatic run_irq();
        int hit;
        issue(1'b1, count_addr, 32'h0000_5000, 1, 1'b0, '0);
        base_cycle = cyc + 2;
        base_val   = 32'h0000_5000;
        issue(1'b1, cmp_addr, base_val + 32'd20, 0, 1'b0, '0);
        hit = base_cycle + 20;  // COUNT matches after this edge, STATUS one edge later
        drain();
        while (cyc < hit + 6) begin
            idle_cycle();
            @(negedge clk);
            rsp_check.check_irq(cyc >= hit + 1);
        end
        issue(1'b0, stat_addr, '0, 0, 1'b0, 32'h1);
        issue(1'b1, stat_addr, 32'h1, 1, 1'b0, '0);
        issue(1'b0, stat_addr, '0, 1, 1'b0, 32'h0);
        drain();
        rsp_check.check_irq(1'b0);
    endtask

    task automatic run_gpio();
        periph_pkg::word_t v;
        periph_pkg::word_t g;
        v = $urandom;
        g = $urandom;
        issue(1'b1, out_addr, v, 0, 1'b0, '0);
        drain();
        rsp_check.check_gpio_out(v);
        issue(1'b0, out_addr, '0, 0, 1'b0, v);
        @(posedge clk);
        cyc++;
        cpu_req <= '0;
        gpio_in <= g;
        issue(1'b0, in_addr, '0, 3, 1'b0, g);
        issue(1'b1, in_addr, 32'hDEAD_BEEF, 0, 1'b0, '0);  // IN ignores writes
        issue(1'b0, out_addr, '0, 0, 1'b0, v);
        drain();
        rsp_check.check_gpio_out(v);
    endtask

    initial begin
        void'($urandom(94));
        rst_n      = 1'b0;
        cpu_req    = '0;
        gpio_in    = '0;
        cyc        = 0;
        base_cycle = 0;
        base_val   = '0;
        build_table();
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;  // COUNT reads the edge index from here on
        @(negedge clk);
        rsp_check.check_idle();
        run_table();
        run_irq();
        if (`ENABLE_PERIPHERAL_GPIO != 0) run_gpio();
        rsp_check.print_summary();
        if (rsp_check.error_total() == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- periph_top.f
+incdir+design
design/periph_pkg.sv
design/data_bus.sv
design/ram_controller.sv
design/timer_controller.sv
design/gpio_controller.sv
design/periph_top.sv
dv/periph_properties.sv
dv/periph_checker.sv
dv/periph_tb.sv

//--- run.sh
#!/bin/sh
# build and run the periph_top testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f periph_top.f --top-module periph_tb -o periph_sim
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

out=$(./obj_dir/periph_sim)
status=$?
echo "$out"

if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "test passed"; then
    exit 0
fi
exit 1
